/* bench/coreBus_properties.sv */
module coreBusProperties import cpuPkg::*; (
   input logic   clk,
   input logic   rstn,
   input logic   RRdy,
   input logic   RWEn,
   input strobeT RWStrobe,
   input logic   Halt
);

   timeunit 1ns;
   timeprecision 1ps;

   noRequestWhenHalted: assert property (@(posedge clk) disable iff (!rstn) Halt |-> !RRdy)
      else $error("memory request raised while the core is halted");

   writeInsideRequest: assert property (@(posedge clk) disable iff (!rstn) RWEn |-> RRdy)
      else $error("write enable raised without a memory request");

   // strobe only travels with a write
   strobeWithWrite: assert property (@(posedge clk) disable iff (!rstn)
      (RWStrobe != '0) == RWEn)
      else $error("byte strobe does not match the write enable");

endmodule

bind lanzonesCore coreBusProperties uBusProps (
   .clk      (clk),
   .rstn     (rstn),
   .RRdy     (RRdy),
   .RWEn     (RWEn),
   .RWStrobe (RWStrobe),
   .Halt     (Halt)
);

/* bench/coreTb.sv */
module coreTb import cpuPkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      wordT   addr;
      wordT   data;
      strobeT strobe;
   } storeT;

   localparam wordT HaltWord = {25'b0, OpHalt};

   logic   clk;
   logic   rstn;
   logic   LEn;
   logic   RVld = 1'b0;
   wordT   RData = '0;
   logic   RRdy;
   wordT   RAddr;
   logic   RWEn;
   wordT   RWData;
   strobeT RWStrobe;
   logic   Halt;

   wordT        mem [256];
   wordT        image [256];      // program plus fill, copied into mem on loadImage
   logic        loadImage;
   logic        busy = 1'b0;
   int          waitLeft = 0;
   logic [31:0] rngState = 32'd74;
   storeT       storeLog [$];
   storeT       expected [$];
   int          logStart;
   int          progLen;
   wordT        nextSlot;
   int          errorCount = 0;
   int          checkCount = 0;

   lanzonesCore UUT (
      .clk      (clk),
      .rstn     (rstn),
      .RVld     (RVld),
      .RData    (RData),
      .LEn      (LEn),
      .RRdy     (RRdy),
      .RAddr    (RAddr),
      .RWEn     (RWEn),
      .RWData   (RWData),
      .RWStrobe (RWStrobe),
      .Halt     (Halt)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // memory model, answers after 1 to 4 cycles
   always @(posedge clk) begin : memoryModel
      logic [31:0] nextState;
      storeT entry;
      wordT mask;
      RVld <= 1'b0;
      if (!rstn) begin
         busy <= 1'b0;
      end
      else if (loadImage) begin
         for (int i = 0; i < 256; i++) begin
            mem[i] = image[i];
         end
         busy <= 1'b0;
      end
      else if (RRdy && !RVld) begin
         if (!busy) begin
            nextState = xorshift32(rngState);
            rngState <= nextState;
            waitLeft <= int'(nextState[1:0]) + 1;
            busy <= 1'b1;
         end
         else if (waitLeft == 1) begin
            RVld <= 1'b1;
            RData <= mem[RAddr[7:0]];
            busy <= 1'b0;
            if (RWEn) begin
               mask = byteMask(RWStrobe);   // only strobed lanes change
               mem[RAddr[7:0]] = (mem[RAddr[7:0]] & ~mask) | (RWData & mask);
               entry.addr = RAddr;
               entry.data = RWData;
               entry.strobe = RWStrobe;
               storeLog.push_back(entry);
            end
         end
         else begin
            waitLeft <= waitLeft - 1;
         end
      end
   end

   task automatic checkWord(input wordT got, input wordT exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkStrobe(input strobeT got, input strobeT exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic checkFlag(input bit got, input bit exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   function automatic wordT encodeR(input logic [6:0] f7, input regAddrT rs2,
                                    input regAddrT rs1, input logic [2:0] f3,
                                    input regAddrT rd);
      return {f7, rs2, rs1, f3, rd, OpReg};
   endfunction

   function automatic wordT encodeI(input logic [6:0] op, input regAddrT rd,
                                    input logic [2:0] f3, input regAddrT rs1, input int imm);
      return {imm[11:0], rs1, f3, rd, op};
   endfunction

   function automatic wordT encodeS(input logic [2:0] f3, input regAddrT rs2,
                                    input regAddrT rs1, input int imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OpStore};
   endfunction

   function automatic wordT encodeLui(input regAddrT rd, input logic [19:0] upper);
      return {upper, rd, OpLui};
   endfunction

   function automatic wordT fillWord(input int idx);
      logic [7:0] a;
      a = idx[7:0];
      return {a, ~a, a ^ 8'h5A, 8'hC3};
   endfunction

   function automatic wordT byteMask(input strobeT s);
      return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
   endfunction

   task automatic startImage();
      for (int i = 0; i < 256; i++) begin
         image[i] = fillWord(i);
      end
      progLen = 0;
      nextSlot = 64;
      expected.delete();
   endtask

   task automatic emit(input wordT w);
      image[progLen] = w;
      progLen++;
   endtask

   task automatic expectStore(input wordT addr, input wordT data, input strobeT strobe);
      storeT entry;
      entry.addr = addr;
      entry.data = data;
      entry.strobe = strobe;
      expected.push_back(entry);
   endtask

   // result lands in x5, then goes to the next slot
   task automatic aluCase(input wordT instr, input wordT result);
      emit(instr);
      emit(encodeS(F3Word, 5, 0, int'(nextSlot)));
      expectStore(nextSlot, result, StrobeWord);
      nextSlot++;
   endtask

   task automatic waitHalt(input string what);
      int cycles;
      cycles = 0;
      while (!Halt && cycles < 5000) begin
         @(negedge clk);
         cycles++;
      end
      if (!Halt) begin
         $display("timeout: the core never halted in %s", what);
         $display("Simulation failed");
         $finish;
      end
   endtask

   task automatic runProgram(input string what);
      @(posedge clk);
      loadImage <= 1'b1;
      @(posedge clk);
      loadImage <= 1'b0;
      LEn <= 1'b1;
      logStart = storeLog.size();
      @(posedge clk);
      LEn <= 1'b0;
      @(negedge clk);
      checkFlag(Halt, 1'b0, {what, " halt after LEn"});
      checkFlag(RRdy, 1'b1, {what, " first fetch"});
      checkWord(RAddr, '0, {what, " first fetch address"});
      waitHalt(what);
   endtask

   task automatic holdsIdle(input int cycles, input string what);
      repeat (cycles) begin
         @(negedge clk);
         checkFlag(Halt, 1'b1, {what, " halt"});
         checkFlag(RRdy, 1'b0, {what, " request"});
         checkFlag(RWEn, 1'b0, {what, " write enable"});
      end
   endtask

   task automatic compareStores(input string what);
      int n;
      storeT got;
      storeT exp;
      wordT mask;
      n = storeLog.size() - logStart;
      checkWord(wordT'(n), wordT'(expected.size()), {what, " store count"});
      for (int i = 0; i < n && i < expected.size(); i++) begin
         got = storeLog[logStart + i];
         exp = expected[i];
         mask = byteMask(exp.strobe);
         checkWord(got.addr, exp.addr, {what, " store address"});
         checkStrobe(got.strobe, exp.strobe, {what, " store strobe"});
         checkWord(got.data & mask, exp.data & mask, {what, " store data"});
         checkWord(mem[exp.addr[7:0]], (image[exp.addr[7:0]] & ~mask) | (exp.data & mask),
                   {what, " memory word"});
      end
   endtask

   task automatic aluProgram(input int aImm, input int bImm, input logic [19:0] upper,
                             input string what);
      wordT a;
      wordT b;
      wordT c;
      wordT iv;
      logic [4:0] sh;
      a = aImm;
      b = bImm;
      c = {upper, 12'b0};
      iv = -300;
      sh = b[4:0];
      startImage();
      emit(encodeI(OpImm, 1, F3AddSub, 0, aImm));
      emit(encodeI(OpImm, 2, F3AddSub, 0, bImm));
      emit(encodeLui(3, upper));
      aluCase(encodeR(Funct7Base, 2, 1, F3AddSub, 5), a + b);
      aluCase(encodeR(Funct7Alt, 2, 1, F3AddSub, 5), a - b);
      aluCase(encodeR(Funct7Base, 2, 1, F3Xor, 5), a ^ b);
      aluCase(encodeR(Funct7Base, 2, 1, F3Or, 5), a | b);
      aluCase(encodeR(Funct7Base, 2, 1, F3And, 5), a & b);
      aluCase(encodeR(Funct7Base, 2, 1, F3Slt, 5), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      aluCase(encodeR(Funct7Base, 2, 1, F3Sltu, 5), (a < b) ? 32'd1 : 32'd0);
      aluCase(encodeR(Funct7Base, 2, 3, F3Sll, 5), c << sh);
      aluCase(encodeR(Funct7Base, 2, 3, F3SrlSra, 5), c >> sh);
      aluCase(encodeR(Funct7Alt, 2, 3, F3SrlSra, 5), wordT'($signed(c) >>> sh));
      aluCase(encodeI(OpImm, 5, F3AddSub, 1, -300), a + iv);
      aluCase(encodeI(OpImm, 5, F3Xor, 2, -300), b ^ iv);
      aluCase(encodeI(OpImm, 5, F3Or, 1, 32'h0F0), a | 32'h0F0);
      aluCase(encodeI(OpImm, 5, F3And, 3, -300), c & iv);
      aluCase(encodeI(OpImm, 5, F3Slt, 1, -300), ($signed(a) < $signed(iv)) ? 32'd1 : 32'd0);
      aluCase(encodeI(OpImm, 5, F3Sltu, 2, -300), (b < iv) ? 32'd1 : 32'd0);
      aluCase(encodeI(OpImm, 5, F3Sll, 2, 9), b << 9);
      aluCase(encodeI(OpImm, 5, F3SrlSra, 3, 7), c >> 7);
      aluCase(encodeI(OpImm, 5, F3SrlSra, 3, 32'h407), wordT'($signed(c) >>> 7));   // srai
      emit(HaltWord);
      runProgram(what);
      compareStores(what);
   endtask

   task automatic loadStoreTest();
      startImage();
      image[100] = 32'h1234_56F0;   // low byte has bit 7 set
      emit(encodeI(OpImm, 10, F3AddSub, 0, 110));
      emit(encodeI(OpLoad, 6, F3Word, 0, 100));
      emit(encodeS(F3Word, 6, 0, 120));
      emit(encodeI(OpLoad, 7, F3Byte, 10, -10));
      emit(encodeS(F3Word, 7, 0, 121));
      emit(encodeI(OpLoad, 8, F3ByteU, 0, 100));
      emit(encodeS(F3Word, 8, 0, 122));
      emit(encodeI(OpImm, 9, F3AddSub, 0, 32'h3AB));
      emit(encodeS(F3Byte, 9, 0, 123));
      emit(encodeI(OpImm, 0, F3AddSub, 0, 55));
      emit(encodeS(F3Word, 0, 0, 124));
      emit(encodeI(OpLoad, 0, F3Word, 0, 100));
      emit(encodeS(F3Word, 0, 0, 125));
      emit(encodeS(F3Word, 6, 10, -4));
      emit(HaltWord);
      expectStore(120, 32'h1234_56F0, StrobeWord);
      expectStore(121, 32'hFFFF_FFF0, StrobeWord);
      expectStore(122, 32'h0000_00F0, StrobeWord);
      expectStore(123, 32'h0000_00AB, StrobeByte);
      expectStore(124, 32'h0, StrobeWord);
      expectStore(125, 32'h0, StrobeWord);
      expectStore(106, 32'h1234_56F0, StrobeWord);
      runProgram("load store");
      compareStores("load store");
   endtask

   task automatic haltTest();
      startImage();
      emit(encodeI(OpImm, 1, F3AddSub, 0, -1));
      emit(encodeS(F3Word, 1, 0, 130));
      emit(HaltWord);
      emit(encodeS(F3Word, 1, 0, 131));   // never reached
      emit(encodeS(F3Word, 1, 0, 132));
      expectStore(130, 32'hFFFF_FFFF, StrobeWord);
      runProgram("halt");
      holdsIdle(20, "after halt");
      compareStores("halt");
   endtask

   task automatic invalidTest(input wordT badWord, input wordT slot, input string what);
      startImage();
      emit(encodeI(OpImm, 1, F3AddSub, 0, 9));
      emit(encodeS(F3Word, 1, 0, int'(slot)));
      emit(badWord);
      emit(encodeS(F3Word, 1, 0, int'(slot) + 1));
      emit(HaltWord);
      expectStore(slot, 32'd9, StrobeWord);
      runProgram(what);
      holdsIdle(5, what);
      compareStores(what);
   endtask

   initial begin
      rstn = 1'b0;
      LEn = 1'b0;
      loadImage = 1'b0;
      repeat (4) @(posedge clk);
      rstn <= 1'b1;
      holdsIdle(20, "after reset");
      aluProgram(-100, 37, 20'h80001, "alu");
      loadStoreTest();
      haltTest();
      invalidTest(32'h0000_000B, 140, "unknown opcode");
      invalidTest(encodeR(7'b0000001, 2, 1, F3AddSub, 5), 142, "bad funct7");
      aluProgram(1500, -2001, 20'h7FF0A, "restart");
      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Simulation completed successfully");
      end
      else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* design/alu.sv */
module alu import cpuPkg::*; (
   input  aluOpT aluOp,
   input  wordT  a,
   input  wordT  b,
   output wordT  aluResult
);

   logic [4:0] shamt;

   assign shamt = b[4:0];   // low 5 bits only

   always_comb begin
      case (aluOp)
         AluAdd: begin
            aluResult = a + b;
         end
         AluSub: begin
            aluResult = a - b;
         end
         AluXor: begin
            aluResult = a ^ b;
         end
         AluOr: begin
            aluResult = a | b;
         end
         AluAnd: begin
            aluResult = a & b;
         end
         AluSlt: begin
            aluResult = {31'b0, $signed(a) < $signed(b)};
         end
         AluSltu: begin
            aluResult = {31'b0, a < b};
         end
         AluSll: begin
            aluResult = a << shamt;
         end
         AluSrl: begin
            aluResult = a >> shamt;
         end
         AluSra: begin
            aluResult = wordT'($signed(a) >>> shamt);
         end
         default: begin
            aluResult = a + b;
         end
      endcase
   end

endmodule

/* design/coreSequencer.sv */
module coreSequencer import cpuPkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    LEn,
   input  logic    RVld,
   input  wordT    RData,
   input  decodedT dec,
   input  wordT    rdata2,
   input  wordT    aluResult,
   output wordT    instr,
   output logic    RRdy,
   output wordT    RAddr,
   output logic    RWEn,
   output wordT    RWData,
   output strobeT  RWStrobe,
   output logic    Halt,
   output logic    wrEn,
   output regAddrT wrAddr,
   output wordT    wrData
);

   seqStateT state;
   wordT     pc;         // word count
   wordT     loadData;
   logic     isMemKind;
   logic     fetchDone;

   assign isMemKind = dec.kind == KindLoad || dec.kind == KindStore;
   assign fetchDone = state == SeqFetch && RRdy && RVld;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= SeqHalted;
         pc <= '0;
         Halt <= 1'b1;
         RRdy <= 1'b0;
         RWEn <= 1'b0;
         RWStrobe <= '0;
      end
      else if (LEn) begin
         // restart from word 0
         state <= SeqFetch;
         pc <= '0;
         Halt <= 1'b0;
         RRdy <= 1'b1;
         RWEn <= 1'b0;
         RWStrobe <= '0;
      end
      else begin
         case (state)
            SeqFetch: begin
               if (!RRdy) begin
                  RRdy <= 1'b1;   // fetch after write-back or a data access
               end
               else if (RVld) begin
                  RRdy <= 1'b0;
                  pc <= pc + 1'b1;
                  state <= SeqExec;
               end
            end
            SeqExec: begin
               case (dec.kind)
                  KindAlu, KindLui: begin
                     state <= SeqFetch;
                  end
                  KindLoad, KindStore: begin
                     RRdy <= 1'b1;
                     RWEn <= dec.kind == KindStore;
                     if (dec.kind == KindStore) begin
                        RWStrobe <= dec.storeByte ? StrobeByte : StrobeWord;
                     end
                     state <= SeqMem;
                  end
                  default: begin
                     Halt <= 1'b1;   // halt opcode or bad instruction
                     state <= SeqHalted;
                  end
               endcase
            end
            SeqMem: begin
               if (RVld) begin
                  RRdy <= 1'b0;
                  RWEn <= 1'b0;
                  RWStrobe <= '0;
                  state <= SeqFetch;
               end
            end
            default: begin
               state <= SeqHalted;   // wait for LEn
            end
         endcase
      end
   end

   // request payload, held while RRdy is up
   always_ff @(posedge clk) begin
      if (fetchDone) begin
         instr <= RData;
      end
      if (LEn) begin
         RAddr <= '0;
      end
      else if (state == SeqFetch && !RRdy) begin
         RAddr <= pc;
      end
      else if (state == SeqExec && isMemKind) begin
         RAddr <= aluResult;
      end
      if (state == SeqExec) begin
         RWData <= dec.storeByte ? {24'b0, rdata2[7:0]} : rdata2;
      end
   end

   always_comb begin
      case (dec.loadSize)
         LoadByte:  loadData = {{24{RData[7]}}, RData[7:0]};
         LoadByteU: loadData = {24'b0, RData[7:0]};
         default:   loadData = RData;
      endcase
   end

   // alu and lui write in execute, loads on the data response
   assign wrEn = (state == SeqExec && (dec.kind == KindAlu || dec.kind == KindLui)) ||
                 (state == SeqMem && RVld && dec.kind == KindLoad);
   assign wrAddr = dec.rd;
   assign wrData = (state == SeqMem) ? loadData :
                   (dec.kind == KindLui) ? dec.imm : aluResult;

endmodule

/* design/cpuPkg.sv */
package cpuPkg;

   localparam int XlenBits = 32;

   typedef logic [XlenBits-1:0] wordT;   // data, instruction and word address
   typedef logic [4:0]          regAddrT;
   typedef logic [3:0]          strobeT;

   // major opcodes
   localparam logic [6:0] OpImm   = 7'b0010011;
   localparam logic [6:0] OpReg   = 7'b0110011;
   localparam logic [6:0] OpLui   = 7'b0110111;
   localparam logic [6:0] OpLoad  = 7'b0000011;
   localparam logic [6:0] OpStore = 7'b0100011;
   localparam logic [6:0] OpHalt  = 7'b1111111;

   localparam logic [2:0] F3AddSub = 3'b000;
   localparam logic [2:0] F3Sll    = 3'b001;
   localparam logic [2:0] F3Slt    = 3'b010;
   localparam logic [2:0] F3Sltu   = 3'b011;
   localparam logic [2:0] F3Xor    = 3'b100;
   localparam logic [2:0] F3SrlSra = 3'b101;
   localparam logic [2:0] F3Or     = 3'b110;
   localparam logic [2:0] F3And    = 3'b111;

   // load and store widths
   localparam logic [2:0] F3Byte  = 3'b000;
   localparam logic [2:0] F3Word  = 3'b010;
   localparam logic [2:0] F3ByteU = 3'b100;

   localparam logic [6:0] Funct7Base = 7'b0000000;
   localparam logic [6:0] Funct7Alt  = 7'b0100000;   // sub, sra, srai

   localparam strobeT StrobeWord = 4'b1111;
   localparam strobeT StrobeByte = 4'b0001;   // lane 0 of the addressed word

   typedef enum logic [3:0] {
      AluAdd,
      AluSub,
      AluXor,
      AluOr,
      AluAnd,
      AluSlt,
      AluSltu,
      AluSll,
      AluSrl,
      AluSra
   } aluOpT;

   typedef enum logic [2:0] {
      KindAlu,
      KindLui,
      KindLoad,
      KindStore,
      KindHalt,
      KindInvalid
   } instrKindT;

   typedef enum logic [1:0] {
      LoadWord,
      LoadByte,
      LoadByteU
   } loadSizeT;

   typedef struct packed {
      instrKindT kind;
      aluOpT     aluOp;
      logic      useImm;
      regAddrT   rd;
      regAddrT   rs1;
      regAddrT   rs2;
      wordT      imm;        // sign-extended, or upper immediate for lui
      loadSizeT  loadSize;
      logic      storeByte;
   } decodedT;

   typedef enum logic [1:0] {
      SeqHalted,
      SeqFetch,
      SeqExec,
      SeqMem
   } seqStateT;

endpackage

/* design/instrDecoder.sv */
module instrDecoder import cpuPkg::*; (
   input  wordT    instr,
   output decodedT dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   wordT       immI;
   wordT       immS;
   logic       isReg;
   logic       altF7;
   logic       funct7Ok;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign isReg = opcode == OpReg;
   assign altF7 = funct7 == Funct7Alt;

   // funct7 is only checked for register ops and immediate shifts
   always_comb begin
      if (!isReg && funct3 != F3Sll && funct3 != F3SrlSra) begin
         funct7Ok = 1'b1;
      end
      else if (funct7 == Funct7Base) begin
         funct7Ok = 1'b1;
      end
      else if (altF7) begin
         funct7Ok = funct3 == F3SrlSra || (isReg && funct3 == F3AddSub);
      end
      else begin
         funct7Ok = 1'b0;
      end
   end

   always_comb begin
      dec.kind = KindInvalid;
      dec.aluOp = AluAdd;   // address add for loads and stores
      dec.useImm = 1'b1;
      dec.rd = instr[11:7];
      dec.rs1 = instr[19:15];
      dec.rs2 = instr[24:20];
      dec.imm = immI;
      dec.loadSize = LoadWord;
      dec.storeByte = 1'b0;

      case (opcode)
         OpImm, OpReg: begin
            dec.kind = funct7Ok ? KindAlu : KindInvalid;
            dec.useImm = !isReg;
            case (funct3)
               F3AddSub: dec.aluOp = (isReg && altF7) ? AluSub : AluAdd;
               F3Sll:    dec.aluOp = AluSll;
               F3Slt:    dec.aluOp = AluSlt;
               F3Sltu:   dec.aluOp = AluSltu;
               F3Xor:    dec.aluOp = AluXor;
               F3SrlSra: dec.aluOp = altF7 ? AluSra : AluSrl;
               F3Or:     dec.aluOp = AluOr;
               F3And:    dec.aluOp = AluAnd;
               default:  dec.aluOp = AluAdd;
            endcase
         end
         OpLui: begin
            dec.kind = KindLui;
            dec.imm = {instr[31:12], 12'b0};
         end
         OpLoad: begin
            dec.kind = KindLoad;
            case (funct3)
               F3Byte:  dec.loadSize = LoadByte;
               F3Word:  dec.loadSize = LoadWord;
               F3ByteU: dec.loadSize = LoadByteU;
               default: dec.kind = KindInvalid;
            endcase
         end
         OpStore: begin
            dec.kind = KindStore;
            dec.imm = immS;
            case (funct3)
               F3Byte:  dec.storeByte = 1'b1;
               F3Word:  dec.storeByte = 1'b0;
               default: dec.kind = KindInvalid;
            endcase
         end
         OpHalt: begin
            dec.kind = KindHalt;
         end
         default: begin
            dec.kind = KindInvalid;
         end
      endcase
   end

endmodule

/* design/lanzonesCore.sv */
module lanzonesCore import cpuPkg::*; (
   input  logic   clk,
   input  logic   rstn,
   input  logic   RVld,
   input  wordT   RData,
   input  logic   LEn,
   output logic   RRdy,
   output wordT   RAddr,
   output logic   RWEn,
   output wordT   RWData,
   output strobeT RWStrobe,
   output logic   Halt
);

   wordT    instr;
   decodedT dec;
   wordT    rdata1;
   wordT    rdata2;
   wordT    aluResult;
   logic    wrEn;
   regAddrT wrAddr;
   wordT    wrData;

   coreSequencer uSeq (
      .clk       (clk),
      .rstn      (rstn),
      .LEn       (LEn),
      .RVld      (RVld),
      .RData     (RData),
      .dec       (dec),
      .rdata2    (rdata2),
      .aluResult (aluResult),
      .instr     (instr),
      .RRdy      (RRdy),
      .RAddr     (RAddr),
      .RWEn      (RWEn),
      .RWData    (RWData),
      .RWStrobe  (RWStrobe),
      .Halt      (Halt),
      .wrEn      (wrEn),
      .wrAddr    (wrAddr),
      .wrData    (wrData)
   );

   instrDecoder uDec (
      .instr (instr),
      .dec   (dec)
   );

   regFile uRegs (
      .clk    (clk),
      .rstn   (rstn),
      .rs1    (dec.rs1),
      .rs2    (dec.rs2),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .rdata1 (rdata1),
      .rdata2 (rdata2)
   );

   alu uAlu (
      .aluOp     (dec.aluOp),
      .a         (rdata1),
      .b         (dec.useImm ? dec.imm : rdata2),   // immediate or rs2
      .aluResult (aluResult)
   );

endmodule

/* design/regFile.sv */
module regFile import cpuPkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  regAddrT rs1,
   input  regAddrT rs2,
   input  logic    wrEn,
   input  regAddrT wrAddr,
   input  wordT    wrData,
   output wordT    rdata1,
   output wordT    rdata2
);

   wordT regs [1:31];   // x0 has no storage

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end
      else if (wrEn && wrAddr != '0) begin
         regs[wrAddr] <= wrData;
      end
   end

   // asynchronous reads, x0 reads as zero
   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module coreTb -f verilog.f -o coreSim || exit 1
out="$(./obj_dir/coreSim)"
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }

/* verilog.f */
design/cpuPkg.sv
design/alu.sv
design/regFile.sv
design/instrDecoder.sv
design/coreSequencer.sv
design/lanzonesCore.sv
bench/coreBus_properties.sv
bench/coreTb.sv
